//--- dv/tbMemStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MEM stage random testbench
// cycle model, checker, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tbMemStage;
    import memPkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_CYCLES   = 4000;
    localparam bit RESET_BEV    = 1'b1;

    logic clk = 1'b0;
    logic rstN, flush, wr, disWr;
    logic [5:0] interrupt;
    exeMemT exeBus;
    dataReqT dataReq;
    logic [31:0] memResult, excVector, epc;
    logic [4:0] memDst;
    regsWrT memRegsWr;
    logic flushException;

    // model state of the MEM register and CP0
    exeMemT mBus;
    logic mDs, mBd;
    cp0StatusT mStatus;
    logic [5:0] mIpHw;
    logic [1:0] mIpSw;
    logic [4:0] mExc;
    logic [31:0] mEpc, mBadV, mCount;
    // predictions for the current cycle
    logic eFlush, eEret, eValid;
    logic [4:0] eCode;
    logic [31:0] eVec, eRes, eData;
    logic [3:0] eStrb;
    regsWrT eWr;
    logic [31:0] rngState = 32'h8c38_2327;
    int numChecks = 0;
    int numErrors = 0;

    memStage #(.RESET_STATUS_BEV(RESET_BEV)) i_dut (
        .clk(clk), .rstN(rstN), .flush(flush), .wr(wr), .disWr(disWr),
        .interrupt(interrupt), .exeBus(exeBus), .dataReq(dataReq),
        .memResult(memResult), .memDst(memDst), .memRegsWr(memRegsWr),
        .flushException(flushException), .excVector(excVector), .epc(epc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        numChecks++;
        if (got !== exp) begin
            numErrors++;
            $display("** Error: %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic misaligned(input logic [1:0] size, input logic [1:0] low);
        return (size == SIZE_HALF && low[0]) || (size == SIZE_WORD && low != 2'b00);
    endfunction

    // architectural view of the CP0 registers
    function automatic logic [31:0] cp0Read(input logic [4:0] sel);
        case (sel)
            5'd8:    return mBadV;
            5'd9:    return mCount;
            5'd12:   return {9'd0, mStatus.bev, 6'd0, mStatus.im, 6'd0, mStatus.exl, mStatus.ie};
            5'd13:   return {mBd, 15'd0, mIpHw, mIpSw, 1'b0, mExc, 2'b00};
            5'd14:   return mEpc;
            default: return 32'd0;
        endcase
    endfunction

    function automatic exeMemT genInstr();
        exeMemT b;
        logic [31:0] r;
        logic [31:0] addr;
        logic [1:0] sz;
        logic [4:0] cpSel;
        r = nextRand();
        b = '0;
        b.pc = {r[31:2], 2'b00} | 32'h0000_1000;
        b.instr = nextRand();
        b.outB = nextRand();
        b.isBranch = (r[11:10] == 2'b00);
        sz = (r[5:4] == 2'd3) ? SIZE_WORD : r[5:4];
        addr = nextRand();
        if (r[9:7] != 3'd0) begin
            if (sz == SIZE_WORD) addr[1:0] = 2'b00;
            else if (sz == SIZE_HALF) addr[0] = 1'b0;
        end else if (sz != SIZE_BYTE) begin
            addr[0] = 1'b1;                     // forced fault
        end
        b.aluOut = addr;
        case (r[14:12])
            3'd0: cpSel = 5'd8;
            3'd1: cpSel = 5'd9;
            3'd2, 3'd3: cpSel = 5'd12;
            3'd4: cpSel = 5'd13;
            default: cpSel = 5'd14;
        endcase
        b.dst = r[20:16];
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: b.regsWr.rfWr = 1'b1;
            4'd4, 4'd5, 4'd6: begin
                b.loadType = '{readMem: 1'b1, size: sz};
                b.regsWr.rfWr = 1'b1;
            end
            4'd7, 4'd8, 4'd9: b.storeType = '{dmWr: 1'b1, size: sz};
            4'd10: begin
                b.regsWr.cp0Wr = 1'b1;
                b.dst = cpSel;
            end
            4'd11, 4'd12: begin
                b.readCp0 = 1'b1;
                b.regsWr.rfWr = 1'b1;
                b.dst = cpSel;
            end
            4'd13: b.exceptType.eret = 1'b1;
            4'd14: b.exceptType = exceptPipeT'(5'b10000 >> r[22:21]);
            default: ;                          // no-op
        endcase
        return b;
    endfunction

    task automatic resetModel();
        mBus = '0;
        mDs = 1'b0;
        mBd = 1'b0;
        mStatus = '{bev: RESET_BEV, im: 8'd0, exl: 1'b0, ie: 1'b0};
        mIpHw = 6'd0;
        mIpSw = 2'd0;
        mExc = 5'd0;
        mEpc = 32'd0;
        mBadV = 32'd0;
        mCount = 32'd0;
    endtask

    task automatic predict();
        logic [7:0] pend;
        pend = {mIpHw, mIpSw} & mStatus.im;
        eFlush = 1'b1;
        eEret = 1'b0;
        eCode = 5'd0;
        if (mStatus.ie && !mStatus.exl && mBus.pc != 32'd0 && pend != 8'd0) eCode = 5'd0;
        else if (mBus.loadType.readMem && misaligned(mBus.loadType.size, mBus.aluOut[1:0]))
            eCode = 5'd4;
        else if (mBus.storeType.dmWr && misaligned(mBus.storeType.size, mBus.aluOut[1:0]))
            eCode = 5'd5;
        else if (mBus.exceptType.syscall) eCode = 5'd8;
        else if (mBus.exceptType.brk) eCode = 5'd9;
        else if (mBus.exceptType.reserved) eCode = 5'd10;
        else if (mBus.exceptType.overflow) eCode = 5'd12;
        else if (mBus.exceptType.eret) eEret = 1'b1;
        else eFlush = 1'b0;
        eVec = eEret ? mEpc : (mStatus.bev ? 32'hBFC0_0380 : 32'h8000_0180);
        eWr = (disWr || eFlush) ? 2'b00 : mBus.regsWr;
        eValid = (mBus.loadType.readMem || mBus.storeType.dmWr) && !eFlush && !disWr;
        case (mBus.storeType.size)
            SIZE_BYTE: eData = {4{mBus.outB[7:0]}};
            SIZE_HALF: eData = {2{mBus.outB[15:0]}};
            default:   eData = mBus.outB;
        endcase
        if (!mBus.storeType.dmWr) eStrb = 4'b0000;
        else if (mBus.storeType.size == SIZE_BYTE) eStrb = 4'b0001 << mBus.aluOut[1:0];
        else if (mBus.storeType.size == SIZE_HALF) eStrb = mBus.aluOut[1] ? 4'b1100 : 4'b0011;
        else eStrb = 4'b1111;
        eRes = mBus.readCp0 ? cp0Read(mBus.dst) : mBus.outB;
    endtask

    // clock edge of the model from this cycle's predictions
    task automatic stepModel();
        mIpHw = interrupt;
        mCount = mCount + 32'd1;
        if (eFlush && !disWr && !eEret) begin
            mStatus.exl = 1'b1;
            mExc = eCode;
            mBd = mDs;
            mEpc = mDs ? mBus.pc - 32'd4 : mBus.pc;
            if (eCode == 5'd4 || eCode == 5'd5) mBadV = mBus.aluOut;
        end else if (eFlush && !disWr) begin
            mStatus.exl = 1'b0;
        end else if (eWr.cp0Wr) begin
            case (mBus.dst)
                5'd12: mStatus = '{bev: mBus.outB[22], im: mBus.outB[15:8],
                                   exl: mBus.outB[1], ie: mBus.outB[0]};
                5'd13: mIpSw = mBus.outB[9:8];
                5'd14: mEpc = mBus.outB;
                5'd9:  mCount = mBus.outB;
                default: ;
            endcase
        end
        if (flush) begin
            mBus = '0;
            mDs = 1'b0;
        end else if (wr) begin
            mDs = mBus.isBranch;                // leaving instruction
            mBus = exeBus;
        end
    endtask

    task automatic checkOutputs();
        checkVal("memDst", {27'd0, memDst}, {27'd0, mBus.dst});
        checkVal("memResult", memResult, eRes);
        checkVal("memRegsWr", {30'd0, memRegsWr}, {30'd0, eWr});
        checkVal("flushException", {31'd0, flushException}, {31'd0, eFlush});
        if (eFlush) checkVal("excVector", excVector, eVec);
        checkVal("epc", epc, mEpc);
        checkVal("dataReq.valid", {31'd0, dataReq.valid}, {31'd0, eValid});
        checkVal("dataReq.we", {31'd0, dataReq.we}, {31'd0, mBus.storeType.dmWr});
        checkVal("dataReq.addr", dataReq.addr, mBus.aluOut);
        checkVal("dataReq.wstrb", {28'd0, dataReq.wstrb}, {28'd0, eStrb});
        if (eValid && mBus.storeType.dmWr) checkVal("dataReq.wdata", dataReq.wdata, eData);
    endtask

    initial begin
        rstN = 1'b0;
        flush = 1'b0;
        wr = 1'b0;
        disWr = 1'b0;
        interrupt = 6'd0;
        exeBus = '0;
        resetModel();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            exeBus = genInstr();
            wr = (nextRand() % 4) != 0;
            flush = (nextRand() % 16) == 0;
            disWr = (nextRand() % 8) == 0;
            if ((nextRand() % 8) == 0) interrupt = 6'(nextRand());
            #1;
            predict();
            checkOutputs();
            @(posedge clk);
            stepModel();
            @(negedge clk);
        end
        $display("checks run %0d, errors %0d", numChecks, numErrors);
        if (numErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // ends a stuck run
    initial begin
        #((NUM_CYCLES + RESET_CYCLES + 4) * CLK_PERIOD + 2000);
        $display("timeout, the test loop did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- rtl/cp0Regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reduced coprocessor 0
// Status Cause EPC BadVAddr Count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cp0Regs #(
    parameter bit RESET_STATUS_BEV = 1'b1
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic [5:0]        interrupt,
    input  logic              cp0Wr,
    input  logic [4:0]        wrAddr,
    input  logic [31:0]       wrData,
    input  logic [4:0]        rdAddr,
    output logic [31:0]       rdData,
    input  logic              excTaken,
    input  logic              isEret,
    input  memPkg::excCodeT   excCode,
    input  logic [31:0]       excPc,
    input  logic              inDelaySlot,
    input  logic [31:0]       badAddr,
    output memPkg::cp0StatusT status,
    output logic [7:0]        ipPending,
    output logic [31:0]       epc
);
    import memPkg::*;

    cp0StatusT   statusQ;
    logic        causeBd;
    logic [7:2]  causeIpHw;     // sampled pins
    logic [1:0]  causeIpSw;     // software interrupts
    excCodeT     causeExc;
    logic [31:0] epcQ;
    logic [31:0] badVAddrQ;
    logic [31:0] countQ;
    logic        commit;
    logic        eretTaken;
    logic [31:0] statusWord;
    logic [31:0] causeWord;

    assign commit    = excTaken && !isEret;
    assign eretTaken = excTaken && isEret;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            statusQ   <= '{bev: RESET_STATUS_BEV, im: 8'd0, exl: 1'b0, ie: 1'b0};
            causeBd   <= 1'b0;
            causeIpHw <= 6'd0;
            causeIpSw <= 2'd0;
            causeExc  <= EXC_INT;
            epcQ      <= 32'd0;
            badVAddrQ <= 32'd0;
            countQ    <= 32'd0;
        end else begin
            causeIpHw <= interrupt;
            countQ    <= countQ + 32'd1;
            if (commit) begin
                statusQ.exl <= 1'b1;
                causeExc    <= excCode;
                causeBd     <= inDelaySlot;
                // restart at the branch when the faulting op is in its slot
                epcQ        <= inDelaySlot ? excPc - 32'd4 : excPc;
                if (excCode == EXC_ADEL || excCode == EXC_ADES) begin
                    badVAddrQ <= badAddr;
                end
            end else if (eretTaken) begin
                statusQ.exl <= 1'b0;
            end else if (cp0Wr) begin
                case (wrAddr)
                    CP0_REG_STATUS: begin
                        statusQ <= '{bev: wrData[22], im: wrData[15:8],
                                     exl: wrData[1], ie: wrData[0]};
                    end
                    CP0_REG_CAUSE: causeIpSw <= wrData[9:8];
                    CP0_REG_EPC:   epcQ      <= wrData;
                    CP0_REG_COUNT: countQ    <= wrData;    // overrides the increment
                    default: ;
                endcase
            end
        end
    end

    // architectural bit positions
    assign statusWord = {9'd0, statusQ.bev, 6'd0, statusQ.im, 6'd0, statusQ.exl, statusQ.ie};
    assign causeWord  = {causeBd, 15'd0, causeIpHw, causeIpSw, 1'b0, causeExc, 2'b00};

    always_comb begin
        case (rdAddr)
            CP0_REG_BADVADDR: rdData = badVAddrQ;
            CP0_REG_COUNT:    rdData = countQ;
            CP0_REG_STATUS:   rdData = statusWord;
            CP0_REG_CAUSE:    rdData = causeWord;
            CP0_REG_EPC:      rdData = epcQ;
            default:          rdData = 32'd0;
        endcase
    end

    assign status    = statusQ;
    assign ipPending = {causeIpHw, causeIpSw} & statusQ.im;
    assign epc       = epcQ;

endmodule

//--- rtl/exceptionUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MEM exception priority encoder
// picks cause code and vector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module exceptionUnit (
    input  memPkg::exeMemT    memBus,
    input  memPkg::cp0StatusT status,
    input  logic [7:0]        ipPending,
    input  logic [31:0]       epc,
    output logic              flushException,
    output memPkg::excCodeT   excCode,
    output logic [31:0]       badAddr,
    output logic              isEret,
    output logic [31:0]       excVector
);
    import memPkg::*;

    logic intTaken;
    logic loadMis;
    logic storeMis;

    function automatic logic isMisaligned(input logic [1:0] size, input logic [1:0] lowAddr);
        logic bad;
        case (size)
            SIZE_HALF: bad = lowAddr[0];
            SIZE_WORD: bad = |lowAddr;
            default:   bad = 1'b0;
        endcase
        return bad;
    endfunction

    // bubbles carry pc 0 and never take an interrupt
    assign intTaken  = status.ie && !status.exl && (memBus.pc != 32'd0) && (|ipPending);
    assign loadMis   = memBus.loadType.readMem
                       && isMisaligned(memBus.loadType.size, memBus.aluOut[1:0]);
    assign storeMis  = memBus.storeType.dmWr
                       && isMisaligned(memBus.storeType.size, memBus.aluOut[1:0]);

    always_comb begin
        flushException = 1'b1;
        isEret         = 1'b0;
        excCode        = EXC_INT;
        badAddr        = 32'd0;
        if (intTaken) begin
            excCode = EXC_INT;
        end else if (loadMis) begin
            excCode = EXC_ADEL;
            badAddr = memBus.aluOut;
        end else if (storeMis) begin
            excCode = EXC_ADES;
            badAddr = memBus.aluOut;
        end else if (memBus.exceptType.syscall) begin
            excCode = EXC_SYS;
        end else if (memBus.exceptType.brk) begin
            excCode = EXC_BP;
        end else if (memBus.exceptType.reserved) begin
            excCode = EXC_RI;
        end else if (memBus.exceptType.overflow) begin
            excCode = EXC_OV;
        end else if (memBus.exceptType.eret) begin
            isEret = 1'b1;          // return, not a real exception
        end else begin
            flushException = 1'b0;
        end
    end

    assign excVector = isEret ? epc : (status.bev ? VECTOR_BEV1 : VECTOR_BEV0);

endmodule

//--- rtl/memPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory stage shared types
// structs, cause codes, CP0 map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package memPkg;

    // access size encoding for loads and stores
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    typedef struct packed {
        logic       readMem;
        logic [1:0] size;
    } loadTypeT;

    typedef struct packed {
        logic       dmWr;
        logic [1:0] size;
    } storeTypeT;

    typedef struct packed {
        logic rfWr;
        logic cp0Wr;
    } regsWrT;

    // flags raised before MEM, interrupts are resolved here
    typedef struct packed {
        logic syscall;
        logic brk;
        logic reserved;
        logic overflow;
        logic eret;
    } exceptPipeT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] aluOut;    // also the data address
        logic [31:0] outB;      // store data / MTC0 data
        loadTypeT    loadType;
        storeTypeT   storeType;
        logic [4:0]  dst;
        regsWrT      regsWr;
        logic        readCp0;
        logic        isBranch;
        exceptPipeT  exceptType;
    } exeMemT;

    typedef struct packed {
        logic        valid;
        logic        we;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } dataReqT;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } excCodeT;

    typedef struct packed {
        logic       bev;
        logic [7:0] im;
        logic       exl;
        logic       ie;
    } cp0StatusT;

    localparam logic [4:0] CP0_REG_BADVADDR = 5'd8;
    localparam logic [4:0] CP0_REG_COUNT    = 5'd9;
    localparam logic [4:0] CP0_REG_STATUS   = 5'd12;
    localparam logic [4:0] CP0_REG_CAUSE    = 5'd13;
    localparam logic [4:0] CP0_REG_EPC      = 5'd14;

    localparam logic [31:0] VECTOR_BEV1 = 32'hBFC0_0380;   // boot ROM handler
    localparam logic [31:0] VECTOR_BEV0 = 32'h8000_0180;   // kseg0 handler

endpackage

//--- rtl/memReg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EXE/MEM pipeline register
// flush, hold, delay slot flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module memReg (
    input  logic           clk,
    input  logic           rstN,
    input  logic           flush,
    input  logic           wr,
    input  memPkg::exeMemT exeBus,
    output memPkg::exeMemT memBus,
    output logic           inDelaySlot
);
    import memPkg::*;

    // flush beats wr, neither means hold
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            memBus <= '0;               // bubble
        end else if (wr) begin
            memBus <= exeBus;
        end
    end

    // the instruction leaving MEM tells whether the incoming one
    // sits in its delay slot
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            inDelaySlot <= 1'b0;
        end else if (wr) begin
            inDelaySlot <= memBus.isBranch;
        end
    end

endmodule

//--- rtl/memStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MEM stage top level
// request, exceptions and bypass
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module memStage #(
    parameter bit RESET_STATUS_BEV = 1'b1
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             flush,
    input  logic             wr,
    input  logic             disWr,
    input  logic [5:0]       interrupt,
    input  memPkg::exeMemT   exeBus,
    output memPkg::dataReqT  dataReq,
    output logic [31:0]      memResult,
    output logic [4:0]       memDst,
    output memPkg::regsWrT   memRegsWr,
    output logic             flushException,
    output logic [31:0]      excVector,
    output logic [31:0]      epc
);
    import memPkg::*;

    exeMemT      memBus;
    logic        inDelaySlot;
    logic [3:0]  wstrb;
    logic [31:0] wdata;
    cp0StatusT   status;
    logic [7:0]  ipPending;
    excCodeT     excCode;
    logic [31:0] badAddr;
    logic        isEret;
    logic [31:0] cp0RdData;
    regsWrT      finalWr;

    memReg uMemReg (
        .clk         (clk),
        .rstN        (rstN),
        .flush       (flush),
        .wr          (wr),
        .exeBus      (exeBus),
        .memBus      (memBus),
        .inDelaySlot (inDelaySlot)
    );

    storeAlign uStoreAlign (
        .storeType (memBus.storeType),
        .addrLow   (memBus.aluOut[1:0]),
        .storeData (memBus.outB),
        .wstrb     (wstrb),
        .wdata     (wdata)
    );

    exceptionUnit uExceptionUnit (
        .memBus         (memBus),
        .status         (status),
        .ipPending      (ipPending),
        .epc            (epc),
        .flushException (flushException),
        .excCode        (excCode),
        .badAddr        (badAddr),
        .isEret         (isEret),
        .excVector      (excVector)
    );

    // stalled or faulting instructions must not touch architectural state
    assign finalWr = (disWr || flushException) ? '0 : memBus.regsWr;

    cp0Regs #(
        .RESET_STATUS_BEV (RESET_STATUS_BEV)
    ) uCp0Regs (
        .clk         (clk),
        .rstN        (rstN),
        .interrupt   (interrupt),
        .cp0Wr       (finalWr.cp0Wr),
        .wrAddr      (memBus.dst),
        .wrData      (memBus.outB),
        .rdAddr      (memBus.dst),
        .rdData      (cp0RdData),
        .excTaken    (flushException && !disWr),   // commit once the stall clears
        .isEret      (isEret),
        .excCode     (excCode),
        .excPc       (memBus.pc),
        .inDelaySlot (inDelaySlot),
        .badAddr     (badAddr),
        .status      (status),
        .ipPending   (ipPending),
        .epc         (epc)
    );

    assign dataReq.valid = (memBus.loadType.readMem || memBus.storeType.dmWr)
                           && !flushException && !disWr;
    assign dataReq.we    = memBus.storeType.dmWr;
    assign dataReq.addr  = memBus.aluOut;       // unmapped
    assign dataReq.wstrb = wstrb;
    assign dataReq.wdata = wdata;

    assign memResult = memBus.readCp0 ? cp0RdData : memBus.outB;    // bypass value
    assign memDst    = memBus.dst;
    assign memRegsWr = finalWr;

endmodule

//--- rtl/storeAlign.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store lane formatting
// byte strobe and replicated data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module storeAlign (
    input  memPkg::storeTypeT storeType,
    input  logic [1:0]        addrLow,
    input  logic [31:0]       storeData,
    output logic [3:0]        wstrb,
    output logic [31:0]       wdata
);
    import memPkg::*;

    always_comb begin
        wstrb = 4'b0000;
        wdata = storeData;
        case (storeType.size)
            SIZE_BYTE: begin
                wdata = {4{storeData[7:0]}};
                if (storeType.dmWr) begin
                    wstrb = 4'b0001 << addrLow;     // one lane
                end
            end
            SIZE_HALF: begin
                wdata = {2{storeData[15:0]}};
                if (storeType.dmWr) begin
                    wstrb = addrLow[1] ? 4'b1100 : 4'b0011;
                end
            end
            default: begin
                if (storeType.dmWr) begin
                    wstrb = 4'b1111;    // full word
                end
            end
        endcase
    end

endmodule

//--- run.sh
#!/bin/bash
# builds and runs the MEM stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -f tb.f --top-module tbMemStage -o simMemStage > build.log 2>&1 \
    && ./obj_dir/simMemStage > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "RESULT: PASS" sim.log && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

//--- tb.f
rtl/memPkg.sv
rtl/memReg.sv
rtl/storeAlign.sv
rtl/exceptionUnit.sv
rtl/cp0Regs.sv
rtl/memStage.sv
dv/tbMemStage.sv
